// ==== Makefile ====
SIM_DIR = obj_dir

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_layer_renderer \
		-Mdir $(SIM_DIR) -f compile.f

run: compile
	./$(SIM_DIR)/Vtb_layer_renderer

clean:
	rm -rf $(SIM_DIR)

// ==== compile.f ====
+incdir+src
src/layer_pkg.sv
src/tile_addr_calc.sv
src/line_fetch_fsm.sv
src/pixel_serializer.sv
src/layer_renderer.sv
verif/vram_model.sv
verif/tb_layer_renderer.sv

// ==== src/layer_consts.svh ====
`ifndef LAYER_CONSTS_SVH
`define LAYER_CONSTS_SVH

////////////////////////////////////////////////////////////////////////
// Video memory bus
////////////////////////////////////////////////////////////////////////

`define BUS_AW 15       // Word address
`define BUS_DW 32

////////////////////////////////////////////////////////////////////////
// Line buffer and display geometry
////////////////////////////////////////////////////////////////////////

`define LB_IDX_W 10
`define LINE_PIXELS 640
`define LINE_IDX_W 9

// Scroll registers cover a 4096 pixel plane
`define SCROLL_W 12

`endif

// ==== src/layer_pkg.sv ====
`include "layer_consts.svh"

package layer_pkg;

    // Colour depth code, 0 is not supported
    typedef enum logic [1:0] {
        DEPTH_2BPP = 2'd1,
        DEPTH_4BPP = 2'd2,
        DEPTH_8BPP = 2'd3
    } depth_e;

    // Layer register set
    typedef struct packed {
        depth_e               depth;
        logic                 tile_w16;
        logic                 tile_h16;
        logic [1:0]           map_w;      // 0:32 1:64 2:128 3:256
        logic [1:0]           map_h;
        logic [7:0]           map_base;   // Units of 128 words
        logic [7:0]           tile_base;
        logic [`SCROLL_W-1:0] hscroll;
        logic [`SCROLL_W-1:0] vscroll;
    } layer_cfg_t;

    typedef struct packed {
        logic [`BUS_AW-1:0] addr;
        logic               strobe;
    } bus_req_t;

    typedef struct packed {
        logic                 en;
        logic [`LB_IDX_W-1:0] idx;
        logic [7:0]           data;
    } lb_write_t;

    // Pattern word handed from fetch to serializer
    typedef struct packed {
        logic [`BUS_DW-1:0] data;
        logic [7:0]         attr;     // Map entry bits 15:8
        logic               start;
    } render_word_t;

endpackage

// ==== src/layer_renderer.sv ====
`timescale 1ns/100ps
`include "layer_consts.svh"

module layer_renderer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`LINE_IDX_W-1:0] line_idx,
    input  logic                   line_render_start,
    input  layer_pkg::layer_cfg_t  cfg,
    input  logic [`BUS_DW-1:0]     bus_rddata,
    input  logic                   bus_ack,
    output layer_pkg::bus_req_t    bus,
    output layer_pkg::lb_write_t   lb_wr
);
    import layer_pkg::*;

    // Fetch side to address arithmetic
    logic [7:0]         htile_cnt;
    logic [1:0]         word_cnt;
    logic [`BUS_DW-1:0] map_word;
    logic [`BUS_AW-1:0] map_addr;
    logic [`BUS_AW-1:0] tile_addr;
    logic               map_odd;
    logic [7:0]         attr;
    logic [3:0]         tile_line;

    // Fetch side to serializer
    render_word_t       render;
    logic               busy;
    logic               line_done;

    tile_addr_calc u_addr (
        .cfg       (cfg),
        .line_idx  (line_idx),
        .htile_cnt (htile_cnt),
        .word_cnt  (word_cnt),
        .map_word  (map_word),
        .map_addr  (map_addr),
        .tile_addr (tile_addr),
        .map_odd   (map_odd),
        .attr      (attr),
        .tile_line (tile_line)
    );

    line_fetch_fsm u_fetch (
        .clk               (clk),
        .rst               (rst),
        .cfg               (cfg),
        .line_render_start (line_render_start),
        .bus_rddata        (bus_rddata),
        .bus_ack           (bus_ack),
        .map_addr          (map_addr),
        .tile_addr         (tile_addr),
        .map_odd           (map_odd),
        .attr              (attr),
        .tile_line         (tile_line),
        .busy              (busy),
        .line_done         (line_done),
        .bus               (bus),
        .htile_cnt         (htile_cnt),
        .word_cnt          (word_cnt),
        .map_word          (map_word),
        .render            (render)
    );

    pixel_serializer u_pix (
        .clk               (clk),
        .rst               (rst),
        .cfg               (cfg),
        .line_render_start (line_render_start),
        .render            (render),
        .busy              (busy),
        .line_done         (line_done),
        .lb_wr             (lb_wr)
    );

endmodule

// ==== src/line_fetch_fsm.sv ====
`timescale 1ns/100ps
`include "layer_consts.svh"

module line_fetch_fsm (
    input  logic                    clk,
    input  logic                    rst,
    input  layer_pkg::layer_cfg_t   cfg,
    input  logic                    line_render_start,
    input  logic [`BUS_DW-1:0]      bus_rddata,
    input  logic                    bus_ack,
    input  logic [`BUS_AW-1:0]      map_addr,
    input  logic [`BUS_AW-1:0]      tile_addr,
    input  logic                    map_odd,
    input  logic [7:0]              attr,
    input  logic [3:0]              tile_line,
    input  logic                    busy,
    input  logic                    line_done,
    output layer_pkg::bus_req_t     bus,
    output logic [7:0]              htile_cnt,
    output logic [1:0]              word_cnt,
    output logic [`BUS_DW-1:0]      map_word,
    output layer_pkg::render_word_t render
);
    import layer_pkg::*;

    typedef enum logic [2:0] {
        IDLE, FETCH_MAP, WAIT_MAP, FETCH_TILE, WAIT_TILE, RENDER
    } state_e;

    state_e             state;
    logic [`BUS_AW-1:0] addr_r;
    logic               strobe_r;
    logic [`BUS_DW-1:0] map_word_r;
    logic [`BUS_DW-1:0] tile_word_r;
    logic [`BUS_DW-1:0] render_data_r;
    logic [7:0]         render_attr_r;
    logic               render_start_r;
    logic [7:0]         htile_cnt_r;
    logic [1:0]         word_cnt_r;
    logic [1:0]         wpl_m1;         // Words per tile line - 1
    logic               two_lines;      // Two tile lines share a word
    logic [`BUS_DW-1:0] line_word;
    logic               issue;

    always_comb begin
        case (cfg.depth)
            DEPTH_2BPP: wpl_m1 = 2'd0;
            DEPTH_4BPP: wpl_m1 = cfg.tile_w16 ? 2'd1 : 2'd0;
            default:    wpl_m1 = cfg.tile_w16 ? 2'd3 : 2'd1;
        endcase
    end

    assign two_lines = (cfg.depth == DEPTH_2BPP) && !cfg.tile_w16;
    assign line_word = !two_lines   ? tile_word_r :
                       tile_line[0] ? {16'd0, tile_word_r[31:16]} : {16'd0, tile_word_r[15:0]};

    assign issue = (state == RENDER) && !busy && !line_done;

    ////////////////////////////////////////////////////////////////////
    // State and counters
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state          <= IDLE;
            strobe_r       <= 1'b0;
            render_start_r <= 1'b0;
            htile_cnt_r    <= 8'd0;
            word_cnt_r     <= 2'd0;
        end else begin
            render_start_r <= issue;
            case (state)
                FETCH_MAP: begin
                    strobe_r <= 1'b1;
                    state    <= WAIT_MAP;
                end
                FETCH_TILE: begin
                    strobe_r <= 1'b1;
                    state    <= WAIT_TILE;
                end
                WAIT_MAP, WAIT_TILE: begin
                    if (bus_ack) begin
                        strobe_r <= 1'b0;
                        state    <= (state == WAIT_MAP) ? FETCH_TILE : RENDER;
                    end
                end
                RENDER: begin
                    if (line_done) begin
                        state <= IDLE;
                    end else if (!busy) begin
                        if (word_cnt_r == wpl_m1) begin
                            word_cnt_r  <= 2'd0;
                            htile_cnt_r <= htile_cnt_r + 8'd1;
                            state       <= map_odd ? FETCH_MAP : FETCH_TILE; // Entry pairs
                        end else begin
                            word_cnt_r <= word_cnt_r + 2'd1;
                            state      <= FETCH_TILE;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
            if (line_render_start) begin
                state       <= FETCH_MAP;
                htile_cnt_r <= 8'd0;
                word_cnt_r  <= 2'd0;
            end
        end
    end

    // Address, fetched words and render payload
    always_ff @(posedge clk) begin
        if (state == FETCH_MAP)
            addr_r <= map_addr;
        else if (state == FETCH_TILE)
            addr_r <= tile_addr;
        if (bus_ack && state == WAIT_MAP)
            map_word_r <= bus_rddata;
        if (bus_ack && state == WAIT_TILE)
            tile_word_r <= bus_rddata;
        if (issue) begin
            render_data_r <= line_word;
            render_attr_r <= attr;
        end
    end

    assign bus       = '{addr: addr_r, strobe: strobe_r && !bus_ack};
    assign render    = '{data: render_data_r, attr: render_attr_r, start: render_start_r};
    assign htile_cnt = htile_cnt_r;
    assign word_cnt  = word_cnt_r;
    assign map_word  = map_word_r;

    a_idle_no_strobe: assert property (@(posedge clk) disable iff (rst)
        (state == IDLE) |-> !bus.strobe);
    a_start_pulse: assert property (@(posedge clk) disable iff (rst)
        render_start_r |=> !render_start_r);

endmodule

// ==== src/pixel_serializer.sv ====
`timescale 1ns/100ps
`include "layer_consts.svh"

module pixel_serializer (
    input  logic                    clk,
    input  logic                    rst,
    input  layer_pkg::layer_cfg_t   cfg,
    input  logic                    line_render_start,
    input  layer_pkg::render_word_t render,
    output logic                    busy,
    output logic                    line_done,
    output layer_pkg::lb_write_t    lb_wr
);
    import layer_pkg::*;

    localparam logic [`LB_IDX_W-1:0] END_IDX  = `LINE_PIXELS;
    localparam logic [`LB_IDX_W-1:0] LAST_IDX = `LINE_PIXELS - 1;

    logic [3:0]           xcnt_r;
    logic [3:0]           xcnt_next;
    logic [3:0]           ppw_m1;         // Pixels per word - 1
    logic [3:0]           hx;
    logic [4:0]           off2;
    logic [4:0]           off4;
    logic [4:0]           off8;
    logic [7:0]           raw_px;
    logic [7:0]           color;
    logic [3:0]           sub_scroll;
    logic [`LB_IDX_W-1:0] idx_r;
    logic [`LB_IDX_W-1:0] idx_next;
    logic                 busy_r;
    logic                 busy_next;
    logic                 done_r;
    logic                 done_next;
    logic                 at_end;
    logic                 active;
    logic                 wr_en_r;
    logic                 wr_en_next;
    logic [`LB_IDX_W-1:0] wr_idx_r;
    logic [7:0]           wr_data_r;

    always_comb begin
        case (cfg.depth)
            DEPTH_2BPP: ppw_m1 = cfg.tile_w16 ? 4'd15 : 4'd7;  // 8 wide uses a half word
            DEPTH_4BPP: ppw_m1 = 4'd7;
            default:    ppw_m1 = 4'd3;
        endcase
    end

    ////////////////////////////////////////////////////////////////////
    // Pixel select, MSB pixel first within a byte
    ////////////////////////////////////////////////////////////////////

    assign hx   = render.attr[2] ? xcnt_r ^ ppw_m1 : xcnt_r;
    assign off2 = {hx[3:2], 3'b000} + {2'b00, ~hx[1:0], 1'b0};
    assign off4 = {hx[2:1], 3'b000} + {2'b00, ~hx[0], 2'b00};
    assign off8 = {hx[1:0], 3'b000};

    always_comb begin
        case (cfg.depth)
            DEPTH_2BPP: raw_px = {6'd0, render.data[off2 +: 2]};
            DEPTH_4BPP: raw_px = {4'd0, render.data[off4 +: 4]};
            default:    raw_px = render.data[off8 +: 8];
        endcase
        color = raw_px;
        if (cfg.depth != DEPTH_8BPP && raw_px[7:4] == 4'd0 && raw_px[3:0] != 4'd0)
            color[7:4] = render.attr[7:4];  // Palette offset
    end

    ////////////////////////////////////////////////////////////////////
    // Counters and write index
    ////////////////////////////////////////////////////////////////////

    assign sub_scroll = cfg.tile_w16 ? cfg.hscroll[3:0] : {1'b0, cfg.hscroll[2:0]};
    assign at_end     = (idx_r == END_IDX);
    assign active     = !at_end && (busy_r || render.start);

    always_comb begin
        xcnt_next  = xcnt_r;
        busy_next  = busy_r;
        idx_next   = idx_r;
        done_next  = done_r || at_end;
        wr_en_next = 1'b0;
        if (active) begin
            if (render.start) begin
                xcnt_next = 4'd1;
                busy_next = 1'b1;
            end else if (xcnt_r == ppw_m1) begin
                xcnt_next = 4'd0;
                busy_next = (idx_r == LAST_IDX);    // Stay busy once the line is full
            end else begin
                xcnt_next = xcnt_r + 4'd1;
            end
            wr_en_next = 1'b1;
            idx_next   = idx_r + 1'b1;
        end
        if (line_render_start) begin
            xcnt_next = 4'd0;
            busy_next = 1'b0;
            done_next = 1'b0;
            idx_next  = '0 - {{(`LB_IDX_W-4){1'b0}}, sub_scroll};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            xcnt_r  <= 4'd0;
            busy_r  <= 1'b0;
            done_r  <= 1'b0;
            idx_r   <= '0;
            wr_en_r <= 1'b0;
        end else begin
            xcnt_r  <= xcnt_next;
            busy_r  <= busy_next;
            done_r  <= done_next;
            idx_r   <= idx_next;
            wr_en_r <= wr_en_next;
        end
    end

    always_ff @(posedge clk) begin
        wr_idx_r  <= idx_r;
        wr_data_r <= color;
    end

    assign busy      = busy_next;
    assign line_done = done_r;
    assign lb_wr     = '{en: wr_en_r, idx: wr_idx_r, data: wr_data_r};

    a_no_write_after_done: assert property (@(posedge clk) disable iff (rst)
        line_done |-> !lb_wr.en);

endmodule

// ==== src/tile_addr_calc.sv ====
`timescale 1ns/100ps
`include "layer_consts.svh"

module tile_addr_calc (
    input  layer_pkg::layer_cfg_t  cfg,
    input  logic [`LINE_IDX_W-1:0] line_idx,
    input  logic [7:0]             htile_cnt,
    input  logic [1:0]             word_cnt,
    input  logic [`BUS_DW-1:0]     map_word,
    output logic [`BUS_AW-1:0]     map_addr,
    output logic [`BUS_AW-1:0]     tile_addr,
    output logic                   map_odd,
    output logic [7:0]             attr,
    output logic [3:0]             tile_line
);
    import layer_pkg::*;

    logic [`SCROLL_W-1:0] scrolled_line;
    logic [7:0]           map_row;
    logic [7:0]           map_col;
    logic [15:0]          map_idx;
    logic [15:0]          map_entry;
    logic [3:0]           tile_y;
    logic [1:0]           hflip_word;
    logic [1:0]           wpl_log;        // log2(words per tile line) + 1
    logic [2:0]           size_log;       // log2(words per tile)
    logic [`BUS_AW-1:0]   tile_rel;

    function automatic logic [7:0] wrap_map(input logic [7:0] idx, input logic [1:0] size);
        return idx & (8'hff >> (2'd3 - size));
    endfunction

    ////////////////////////////////////////////////////////////////////
    // Scroll and map wrap
    ////////////////////////////////////////////////////////////////////

    assign scrolled_line = {{(`SCROLL_W-`LINE_IDX_W){1'b0}}, line_idx} + cfg.vscroll;

    assign map_row = wrap_map(cfg.tile_h16 ? scrolled_line[11:4] : scrolled_line[10:3],
                              cfg.map_h);
    assign map_col = wrap_map(htile_cnt + (cfg.tile_w16 ? cfg.hscroll[11:4] : cfg.hscroll[10:3]),
                              cfg.map_w);

    assign map_idx  = ({8'd0, map_row} << (3'd5 + {1'b0, cfg.map_w})) | {8'd0, map_col};
    assign map_addr = {cfg.map_base, 7'd0} + map_idx[15:1];  // Two entries per word
    assign map_odd  = map_idx[0];

    ////////////////////////////////////////////////////////////////////
    // Map entry and tile address
    ////////////////////////////////////////////////////////////////////

    assign map_entry = map_odd ? map_word[31:16] : map_word[15:0];
    assign attr      = map_entry[15:8];

    assign tile_y     = cfg.tile_h16 ? scrolled_line[3:0] : {1'b0, scrolled_line[2:0]};
    assign tile_line  = map_entry[11] ? tile_y ^ (cfg.tile_h16 ? 4'd15 : 4'd7) : tile_y;
    assign hflip_word = map_entry[10] ? ~word_cnt : word_cnt;

    always_comb begin
        case (cfg.depth)
            DEPTH_2BPP: wpl_log = cfg.tile_w16 ? 2'd1 : 2'd0;
            DEPTH_4BPP: wpl_log = cfg.tile_w16 ? 2'd2 : 2'd1;
            default:    wpl_log = cfg.tile_w16 ? 2'd3 : 2'd2;
        endcase
    end

    assign size_log = 3'd2 + {2'b0, cfg.tile_h16} + {1'b0, wpl_log};

    // Word offset inside the tile
    always_comb begin
        case (wpl_log)
            2'd0:    tile_rel = {12'd0, tile_line[3:1]};     // Two lines per word
            2'd1:    tile_rel = {11'd0, tile_line};
            2'd2:    tile_rel = {10'd0, tile_line, hflip_word[0]};
            default: tile_rel = {9'd0, tile_line, hflip_word};
        endcase
    end

    assign tile_addr = {cfg.tile_base, 7'd0} + ({5'd0, map_entry[9:0]} << size_log) + tile_rel;

endmodule

// ==== verif/tb_layer_renderer.sv ====
`timescale 1ns/100ps
`include "layer_consts.svh"

module tb_layer_renderer;
    import layer_pkg::*;

    localparam integer CLK_PERIOD  = 40;
    localparam integer DRIVE_DELAY = 2;
    localparam integer LINE_CYCLES = `LINE_PIXELS * 12;     // Budget per line
    localparam integer WATCHDOG_NS = 6 * LINE_CYCLES * CLK_PERIOD;
    localparam integer LB_SIZE     = 1 << `LB_IDX_W;

    logic                   clk;
    logic                   rst;
    logic [`LINE_IDX_W-1:0] line_idx;
    logic                   line_render_start;
    layer_cfg_t             cfg;
    logic [`BUS_DW-1:0]     bus_rddata;
    logic                   bus_ack;
    bus_req_t               bus;
    lb_write_t              lb_wr;

    // Captured line buffer
    logic [7:0]             line_buf [0:LB_SIZE-1];
    logic                   written  [0:LB_SIZE-1];
    logic                   line_ended;
    integer                 write_cnt;
    integer                 errors;
    logic                   prev_strobe;
    logic [`BUS_AW-1:0]     prev_addr;
    integer                 i;

    layer_renderer UUT (
        .clk               (clk),
        .rst               (rst),
        .line_idx          (line_idx),
        .line_render_start (line_render_start),
        .cfg               (cfg),
        .bus_rddata        (bus_rddata),
        .bus_ack           (bus_ack),
        .bus               (bus),
        .lb_wr             (lb_wr)
    );

    vram_model vram (
        .clk    (clk),
        .rst    (rst),
        .bus    (bus),
        .rddata (bus_rddata),
        .ack    (bus_ack)
    );

    task automatic fail_check(input string msg);
        errors = errors + 1;
        $display("Error at %0t ns: %s", $time, msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    ////////////////////////////////////////////////////////////////////
    // Clock and watchdog
    ////////////////////////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        abort_run("Watchdog expired before the tests finished");
    end

    ////////////////////////////////////////////////////////////////////
    // Bus monitor and line buffer capture, sampled mid cycle
    ////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (rst || line_render_start) begin
            for (i = 0; i < LB_SIZE; i++)
                written[i] = 1'b0;
            line_ended = 1'b0;
            write_cnt  = 0;
        end
        if (!rst) begin
            assert (!(bus.strobe && bus_ack))
                else fail_check("bus strobe high in an ack cycle");
            if (prev_strobe && bus.strobe)
                assert (bus.addr == prev_addr)
                    else fail_check($sformatf("bus address moved from %h to %h under strobe",
                                              prev_addr, bus.addr));
            if (lb_wr.en) begin
                assert (!line_ended)
                    else fail_check($sformatf("write to idx %0d after idx 639", lb_wr.idx));
                line_buf[lb_wr.idx] = lb_wr.data;
                written[lb_wr.idx]  = 1'b1;
                write_cnt           = write_cnt + 1;
                if (lb_wr.idx == `LINE_PIXELS - 1)
                    line_ended = 1'b1;              // End of line marker
            end
        end
        prev_strobe = bus.strobe;
        prev_addr   = bus.addr;
    end

    ////////////////////////////////////////////////////////////////////
    // Reference model from the memory layout rules
    ////////////////////////////////////////////////////////////////////

    function automatic logic [7:0] model_pixel(input integer scr_x);
        integer      tw, th, bpp, mw, mh;
        integer      px, py, tx, ty, map_idx, tile_words, pos;
        logic [31:0] word;
        logic [15:0] ent;
        logic [7:0]  byte_val;
        logic [7:0]  mask;
        logic [7:0]  raw;
        tw  = cfg.tile_w16 ? 16 : 8;
        th  = cfg.tile_h16 ? 16 : 8;
        bpp = (cfg.depth == DEPTH_2BPP) ? 2 : (cfg.depth == DEPTH_4BPP) ? 4 : 8;
        mw  = 32 << cfg.map_w;
        mh  = 32 << cfg.map_h;
        px  = (scr_x + cfg.hscroll) % 4096;     // Plane coordinates
        py  = (line_idx + cfg.vscroll) % 4096;
        map_idx = ((py / th) % mh) * mw + (px / tw) % mw;
        word = vram.mem[(cfg.map_base * 128 + map_idx / 2) % 32768];
        ent  = (map_idx % 2 == 1) ? word[31:16] : word[15:0];
        tx = px % tw;
        ty = py % th;
        if (ent[10])
            tx = tw - 1 - tx;
        if (ent[11])
            ty = th - 1 - ty;
        // Tile is one bit stream, ascending bytes, MSB pixel first
        tile_words = th * tw * bpp / 32;
        pos  = (ty * tw + tx) * bpp;
        word = vram.mem[(cfg.tile_base * 128 + ent[9:0] * tile_words + pos / 32) % 32768];
        byte_val = word[((pos % 32) / 8) * 8 +: 8];
        mask     = 8'hff >> (8 - bpp);
        raw      = (byte_val >> (8 - bpp - pos % 8)) & mask;
        if (bpp != 8 && raw != 8'd0 && raw[7:4] == 4'd0)
            raw[7:4] = ent[15:12];
        return raw;
    endfunction

    function automatic layer_cfg_t make_cfg(
        input depth_e d, input logic w16, input logic h16, input logic [1:0] mw,
        input logic [1:0] mh, input logic [7:0] mb, input logic [7:0] tb,
        input logic [11:0] hs, input logic [11:0] vs);
        return '{depth: d, tile_w16: w16, tile_h16: h16, map_w: mw, map_h: mh,
                 map_base: mb, tile_base: tb, hscroll: hs, vscroll: vs};
    endfunction

    // Map entry with flips and palette varying by column
    function automatic logic [15:0] flip_entry(input integer n);
        logic [9:0] tile;
        logic [3:0] pal;
        tile = n[9:0] * 10'd29 + 10'd5;
        pal  = n[3:0] ^ 4'h9;
        return {pal, n[1], n[0], tile};
    endfunction

    ////////////////////////////////////////////////////////////////////
    // Line rendering and checking
    ////////////////////////////////////////////////////////////////////

    task automatic render_line(input layer_cfg_t c, input logic [`LINE_IDX_W-1:0] line);
        integer cycles;
        @(posedge clk);
        #DRIVE_DELAY;
        cfg               = c;
        line_idx          = line;
        line_render_start = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        line_render_start = 1'b0;
        cycles = 0;
        while (!line_ended && cycles < LINE_CYCLES) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        if (!line_ended)
            abort_run($sformatf("Line %0d never reached its last pixel write", line));
        repeat (16) @(posedge clk);                 // Quiet period, monitor flags late writes
    endtask

    task automatic check_line(input string name);
        integer     x;
        integer     sub;
        logic [7:0] exp;
        sub = cfg.tile_w16 ? cfg.hscroll % 16 : cfg.hscroll % 8;
        assert (write_cnt == `LINE_PIXELS + sub)
            else fail_check($sformatf("%s: %0d writes, expected %0d", name, write_cnt,
                                      `LINE_PIXELS + sub));
        for (x = 0; x < `LINE_PIXELS; x++) begin
            exp = model_pixel(x);
            assert (written[x])
                else fail_check($sformatf("%s: idx %0d never written", name, x));
            assert (line_buf[x] == exp)
                else fail_check($sformatf("%s: idx %0d is %02h, expected %02h", name, x,
                                          line_buf[x], exp));
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////

    task automatic test_reset_state();
        repeat (10) begin
            @(negedge clk);
            assert (!bus.strobe) else fail_check("bus strobe high before any start");
            assert (!lb_wr.en) else fail_check("line buffer write before any start");
        end
    endtask

    task automatic test_8bpp();
        render_line(make_cfg(DEPTH_8BPP, 1'b0, 1'b0, 2'd2, 2'd2, 8'h10, 8'h40,
                             12'd0, 12'd0), 9'd37);
        check_line("8bpp 8x8");
    endtask

    task automatic test_4bpp_flips();
        integer base;
        integer k;
        base = 8 * 128 + 32;                        // Row 1 of a 64 wide map at base 8
        for (k = 0; k < 20; k++)
            vram.mem[base + k] = {flip_entry(2 * k + 1), flip_entry(2 * k)};
        render_line(make_cfg(DEPTH_4BPP, 1'b1, 1'b1, 2'd1, 2'd1, 8'h08, 8'h20,
                             12'd0, 12'd0), 9'd21);
        check_line("4bpp 16x16 flips");
    endtask

    task automatic test_2bpp_lines();
        render_line(make_cfg(DEPTH_2BPP, 1'b0, 1'b0, 2'd1, 2'd1, 8'h30, 8'h90,
                             12'd0, 12'd0), 9'd13);
        check_line("2bpp odd line");
        render_line(make_cfg(DEPTH_2BPP, 1'b0, 1'b0, 2'd1, 2'd1, 8'h30, 8'h90,
                             12'd0, 12'd0), 9'd14);
        check_line("2bpp even line");
    endtask

    // 32x32 map, both axes wrap
    task automatic test_scroll_wrap();
        render_line(make_cfg(DEPTH_8BPP, 1'b1, 1'b0, 2'd0, 2'd0, 8'h50, 8'h18,
                             12'd1237, 12'd3001), 9'd200);
        check_line("scroll and wrap");
    endtask

    initial begin
        errors            = 0;
        rst               = 1'b1;
        line_idx          = '0;
        line_render_start = 1'b0;
        cfg               = make_cfg(DEPTH_8BPP, 1'b0, 1'b0, 2'd0, 2'd0, 8'h00, 8'h00,
                                     12'd0, 12'd0);
        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        test_reset_state();
        test_8bpp();
        test_4bpp_flips();
        test_2bpp_lines();
        test_scroll_wrap();
        if (errors == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("Some tests failed");
            $fatal(1);
        end
    end

endmodule

// ==== verif/vram_model.sv ====
`timescale 1ns/100ps
`include "layer_consts.svh"

module vram_model (
    input  logic                clk,
    input  logic                rst,
    input  layer_pkg::bus_req_t bus,
    output logic [`BUS_DW-1:0]  rddata,
    output logic                ack
);

    localparam integer WORDS = 1 << `BUS_AW;

    logic [`BUS_DW-1:0] mem [0:WORDS-1];
    integer             seed;
    integer             wait_cnt;       // Cycles left until ack
    integer             i;

    initial begin
        seed = 32'h6b5d;
        for (i = 0; i < WORDS; i++)
            mem[i] = $random(seed);
    end

    // Outputs change a little after the rising edge, like the testbench inputs
    initial begin
        ack      = 1'b0;
        rddata   = '0;
        wait_cnt = 0;
        forever begin
            @(posedge clk);
            #2;
            if (rst) begin
                ack      = 1'b0;
                wait_cnt = 0;
            end else if (ack) begin
                ack = 1'b0;                         // One cycle pulse
            end else if (wait_cnt > 0) begin
                wait_cnt = wait_cnt - 1;
                if (wait_cnt == 0) begin
                    rddata = mem[bus.addr];
                    ack    = 1'b1;
                end
            end else if (bus.strobe) begin
                wait_cnt = 1 + ($random(seed) & 3);  // 1 to 4 cycles
            end
        end
    end

endmodule
